// File: mem_subsys.f
+incdir+verilog
verilog/mem_map_pkg.sv
verilog/mem_bus_pkg.sv
verilog/region_decoder.sv
verilog/unified_ram.sv
verilog/debug_apb_master.sv
verilog/core_resp_router.sv
verilog/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "sim: failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_mem_subsys.sv
/* Acts as the core on both ports and models the debug module on APB
   RAM reads only target words written earlier in the run */
`timescale 1ns/100ps

module tb_mem_subsys
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int    CLK_HALF       = 10;
  localparam int    RESET_CYCLES   = 16;
  // Budget of 16 cycles per transaction
  localparam int    MAX_TRANS      = 400;
  localparam int    TIMEOUT_CYCLES = MAX_TRANS * 16;
  localparam int    RAM_WORDS      = 4096;
  localparam int    DM_REGS        = 64;
  localparam addr_t RAM_BASE       = 32'h0001_0000;
  localparam addr_t RAM_BYTES      = 32'h0000_4000;
  localparam addr_t ALIAS_BASE     = 32'hFFFF_C000;
  localparam addr_t DBG_START      = 32'h0000_0200;
  localparam addr_t DBG_END        = 32'h0000_0FFF;
  localparam addr_t TOHOST_ADDR    = 32'h8000_1000;

  logic      clk;
  logic      reset_n;
  imem_req_t i_imem;
  dmem_req_t i_dmem;
  logic      i_debug_mode;
  core_rsp_t o_imem;
  core_rsp_t o_dmem;
  word_t     o_tohost;
  apb_req_t  o_dm_apb;
  apb_rsp_t  i_dm_apb;

  // Expected contents of RAM and debug registers
  word_t       shadow_ram [RAM_WORDS];
  word_t       shadow_dbg [DM_REGS];
  int          written[$];
  // Debug module state and last transfer seen
  word_t       dm_regs [DM_REGS];
  logic [5:0]  dm_idx;
  int          dm_wait;
  int          apb_count = 0;
  apb_addr_t   last_paddr;
  logic        last_pwrite;
  word_t       last_pwdata;
  word_t       exp_dmem;
  word_t       exp_imem;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  mem_subsys_top mem_subsys_top_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_imem       (i_imem),
    .i_dmem       (i_dmem),
    .i_debug_mode (i_debug_mode),
    .o_imem       (o_imem),
    .o_dmem       (o_dmem),
    .o_tohost     (o_tohost),
    .o_dm_apb     (o_dm_apb),
    .i_dm_apb     (i_dm_apb)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // ==================================================
  // Address helpers and reference model
  // ==================================================
  // Power-up value of a debug register, unique per index
  function automatic word_t dbg_fill(input int idx);
    return 32'hDB60_0000 ^ (word_t'(idx) * 32'h0001_0409);
  endfunction

  function automatic addr_t ram_addr(input int idx);
    return RAM_BASE + addr_t'(idx) * 4;
  endfunction

  function automatic addr_t alias_addr(input int idx);
    return ALIAS_BASE | (addr_t'(idx) << 2);
  endfunction

  // Random 256-byte block inside the debug area, register in bits 7:2
  function automatic addr_t dbg_addr(input int reg_num);
    return DBG_START + addr_t'($urandom_range(13, 0)) * 256 + addr_t'(reg_num) * 4;
  endfunction

  // Well above RAM, below tohost and clear of the alias
  function automatic addr_t unmapped_addr();
    return 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);
  endfunction

  function automatic int pick_written();
    return written[$urandom_range(written.size() - 1, 0)];
  endfunction

  // RAM word for linear range or top alias, -1 elsewhere
  function automatic int ram_index(input addr_t addr);
    addr_t offset;
    offset = addr - RAM_BASE;
    if (addr >= RAM_BASE && offset < RAM_BYTES)
      return int'(offset >> 2);
    if (addr[31:14] == 18'h3_FFFF)
      return int'(addr[13:2]);
    return -1;
  endfunction

  function automatic logic in_debug_area(input logic dbg_mode, input addr_t addr);
    return dbg_mode && (addr >= DBG_START) && (addr <= DBG_END);
  endfunction

  // Expected read word for one access
  function automatic word_t expected_read(input logic dbg_mode, input addr_t addr);
    int idx;
    idx = ram_index(addr);
    if (in_debug_area(dbg_mode, addr))
      return shadow_dbg[addr[7:2]];
    else if (idx >= 0)
      return shadow_ram[idx];
    else
      return '0;
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    errors++;
    $display("[FAIL] %s: got %h, expected %h", name, got, exp);
  endtask

  // ==================================================
  // Core-side drivers
  // ==================================================
  task automatic data_write(input addr_t addr, input word_t data);
    int idx;
    @(negedge clk);
    i_dmem.addr   = addr;
    i_dmem.wdata  = data;
    i_dmem.wvalid = 1'b1;
    @(posedge clk);
    while (!o_dmem.wready)
      @(posedge clk);
    // Write took effect at this edge
    idx = ram_index(addr);
    if (in_debug_area(i_debug_mode, addr))
      shadow_dbg[addr[7:2]] = data;
    else if (idx >= 0)
      shadow_ram[idx] = data;
    @(negedge clk);
    i_dmem.wvalid = 1'b0;
  endtask

  task automatic data_read(input addr_t addr);
    @(negedge clk);
    i_dmem.addr   = addr;
    i_dmem.rready = 1'b1;
    @(posedge clk);
    while (!o_dmem.rvalid)
      @(posedge clk);
    @(negedge clk);
    i_dmem.rready = 1'b0;
  endtask

  task automatic fetch(input addr_t addr);
    @(negedge clk);
    i_imem.addr   = addr;
    i_imem.rready = 1'b1;
    @(posedge clk);
    while (!o_imem.rvalid)
      @(posedge clk);
    @(negedge clk);
    i_imem.rready = 1'b0;
  endtask

  // Last APB transfer against the access that caused it
  task automatic check_apb(input addr_t addr, input logic write);
    checks++;
    if (last_paddr !== addr[12:0])
      report_mismatch("paddr", word_t'(last_paddr), word_t'(addr[12:0]));
    checks++;
    if (last_pwrite !== write)
      report_mismatch("pwrite", word_t'(last_pwrite), word_t'(write));
  endtask

  // ==================================================
  // Debug module model, 0 to 3 wait states
  // ==================================================
  always @(negedge clk)
  begin
    if (reset_n && o_dm_apb.psel && !o_dm_apb.penable)
    begin
      dm_wait         = $urandom_range(3, 0);
      i_dm_apb.pready = 1'b0;
    end
    else if (reset_n && o_dm_apb.psel && dm_wait > 0)
    begin
      dm_wait--;
      i_dm_apb.pready = 1'b0;
    end
    else if (reset_n && o_dm_apb.psel && !i_dm_apb.pready)
    begin
      dm_idx          = o_dm_apb.paddr[7:2];
      i_dm_apb.prdata = dm_regs[dm_idx];
      if (o_dm_apb.pwrite)
        dm_regs[dm_idx] = o_dm_apb.pwdata;
      last_paddr      = o_dm_apb.paddr;
      last_pwrite     = o_dm_apb.pwrite;
      last_pwdata     = o_dm_apb.pwdata;
      apb_count++;
      i_dm_apb.pready = 1'b1;
    end
    else
      i_dm_apb.pready = 1'b0;
  end

  // ==================================================
  // Read data compare and watchdog
  // ==================================================
  always @(posedge clk)
  begin
    if (reset_n && o_dmem.rvalid)
    begin
      exp_dmem = expected_read(i_debug_mode, i_dmem.addr);
      checks++;
      if (o_dmem.rdata !== exp_dmem)
      begin
        errors++;
        $display("[FAIL] o_dmem.rdata addr %h: got %h, expected %h",
                 i_dmem.addr, o_dmem.rdata, exp_dmem);
      end
    end
    if (reset_n && o_imem.rvalid)
    begin
      exp_imem = expected_read(i_debug_mode, i_imem.addr);
      checks++;
      if (o_imem.rdata !== exp_imem)
      begin
        errors++;
        $display("[FAIL] o_imem.rdata addr %h: got %h, expected %h",
                 i_imem.addr, o_imem.rdata, exp_imem);
      end
    end
    // Fetch port has no write handshake
    if (reset_n && o_imem.wready !== 1'b0)
    begin
      errors++;
      $display("[FAIL] o_imem.wready: got %h, expected %h", o_imem.wready, 1'b0);
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: no handshake completed the run within %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial
  begin
    addr_t addr;
    word_t data;
    int    idx;
    int    other;
    int    apb_before;
    word_t tohost_before;

    void'($urandom(32'hae54));
    i_imem       = '0;
    i_dmem       = '0;
    i_debug_mode = 1'b0;
    i_dm_apb     = '0;
    reset_n      = 1'b0;
    for (int i = 0; i < DM_REGS; i++)
    begin
      dm_regs[i]    = dbg_fill(i);
      shadow_dbg[i] = dbg_fill(i);
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b1;

    // Idle APB and cleared tohost out of reset
    checks++;
    if (o_dm_apb.psel !== 1'b0)
      report_mismatch("o_dm_apb.psel", word_t'(o_dm_apb.psel), '0);
    checks++;
    if (o_tohost !== '0)
      report_mismatch("o_tohost", o_tohost, '0);

    // Normal mode writes then reads in random order
    for (int i = 0; i < 48; i++)
    begin
      idx = int'($urandom_range(RAM_WORDS - 1, 0));
      data_write(ram_addr(idx), $urandom);
      written.push_back(idx);
    end
    for (int i = 0; i < 48; i++)
      data_read(ram_addr(pick_written()));

    // Fetch of data-written words, then both ports at once
    for (int i = 0; i < 16; i++)
    begin
      idx = int'($urandom_range(RAM_WORDS - 1, 0));
      data_write(ram_addr(idx), $urandom);
      written.push_back(idx);
      fetch(ram_addr(idx));
    end
    for (int i = 0; i < 16; i++)
    begin
      idx   = pick_written();
      other = pick_written();
      fork
        data_read(ram_addr(idx));
        fetch(ram_addr(other));
      join
    end

    // Top alias hits the word at its low 14 bits
    for (int i = 0; i < 16; i++)
    begin
      idx = int'($urandom_range(RAM_WORDS - 1, 0));
      data_write(alias_addr(idx), $urandom);
      written.push_back(idx);
      data_read(ram_addr(idx));
    end
    for (int i = 0; i < 8; i++)
    begin
      idx = int'($urandom_range(RAM_WORDS - 1, 0));
      data_write(ram_addr(idx), $urandom);
      written.push_back(idx);
      fetch(alias_addr(idx));
    end

    // Debug area over APB
    @(negedge clk);
    i_debug_mode = 1'b1;
    for (int i = 0; i < 16; i++)
    begin
      addr = dbg_addr(int'($urandom_range(DM_REGS - 1, 0)));
      data = $urandom;
      data_write(addr, data);
      check_apb(addr, 1'b1);
      checks++;
      if (last_pwdata !== data)
        report_mismatch("pwdata", last_pwdata, data);
      addr = dbg_addr(int'($urandom_range(DM_REGS - 1, 0)));
      data_read(addr);
      check_apb(addr, 1'b0);
      addr = dbg_addr(int'($urandom_range(DM_REGS - 1, 0)));
      fetch(addr);
      check_apb(addr, 1'b0);
    end
    for (int i = 0; i < 4; i++)
    begin
      idx   = int'($urandom_range(DM_REGS - 1, 0));
      other = int'($urandom_range(DM_REGS - 1, 0));
      fork
        data_read(dbg_addr(idx));
        fetch(dbg_addr(other));
      join
    end

    // Unmapped in debug mode, zero on read and writes dropped
    apb_before    = apb_count;
    tohost_before = o_tohost;
    for (int i = 0; i < 8; i++)
    begin
      data_read(unmapped_addr());
      fetch(unmapped_addr());
      data_write(unmapped_addr(), $urandom);
    end
    checks++;
    if (apb_count != apb_before)
    begin
      errors++;
      $display("Unmapped accesses reached the debug module: %0d transfers",
               apb_count - apb_before);
    end
    checks++;
    if (o_tohost !== tohost_before)
      report_mismatch("o_tohost", o_tohost, tohost_before);
    data_read(ram_addr(pick_written()));

    // tohost in debug mode, then in normal mode
    for (int i = 0; i < 8; i++)
    begin
      if (i == 4)
      begin
        @(negedge clk);
        i_debug_mode = 1'b0;
      end
      data = $urandom;
      data_write(TOHOST_ADDR, data);
      checks++;
      if (o_tohost !== data)
        report_mismatch("o_tohost", o_tohost, data);
    end

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: verilog/mem_subsys_top.sv
/* Memory subsystem between the core ports, unified RAM and debug APB
   One request outstanding per core port, both ports may run at once */
`timescale 1ns/100ps

module mem_subsys_top
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  imem_req_t i_imem,
  input  dmem_req_t i_dmem,
  input  logic      i_debug_mode,
  output core_rsp_t o_imem,
  output core_rsp_t o_dmem,
  output word_t     o_tohost,
  output apb_req_t  o_dm_apb,
  input  apb_rsp_t  i_dm_apb
);

  region_t  imem_region;
  region_t  dmem_region;
  ram_idx_t imem_idx;
  ram_idx_t dmem_idx;
  logic     imem_ram_rd;
  logic     dmem_ram_rd;
  logic     dmem_ram_wr;
  logic     ram_imem_valid;
  logic     ram_dmem_valid;
  word_t    ram_imem_data;
  word_t    ram_dmem_data;
  logic     apb_done_imem;
  logic     apb_done_dmem;
  logic     apb_write;
  word_t    apb_rdata;

  // RAM enables from the decoded regions
  assign imem_ram_rd = i_imem.rready && (imem_region == REG_RAM);
  assign dmem_ram_rd = i_dmem.rready && (dmem_region == REG_RAM);
  assign dmem_ram_wr = i_dmem.wvalid && (dmem_region == REG_RAM);

  region_decoder imem_dec_i (
    .i_addr       (i_imem.addr),
    .i_debug_mode (i_debug_mode),
    .o_region     (imem_region),
    .o_ram_idx    (imem_idx)
  );

  region_decoder dmem_dec_i (
    .i_addr       (i_dmem.addr),
    .i_debug_mode (i_debug_mode),
    .o_region     (dmem_region),
    .o_ram_idx    (dmem_idx)
  );

  unified_ram unified_ram_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_imem_rd    (imem_ram_rd),
    .i_imem_idx   (imem_idx),
    .i_dmem_rd    (dmem_ram_rd),
    .i_dmem_wr    (dmem_ram_wr),
    .i_dmem_idx   (dmem_idx),
    .i_wdata      (i_dmem.wdata),
    .o_imem_valid (ram_imem_valid),
    .o_imem_data  (ram_imem_data),
    .o_dmem_valid (ram_dmem_valid),
    .o_dmem_data  (ram_dmem_data)
  );

  debug_apb_master debug_apb_master_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_req    (i_imem),
    .i_dmem_req    (i_dmem),
    .i_imem_region (imem_region),
    .i_dmem_region (dmem_region),
    .o_apb         (o_dm_apb),
    .i_apb         (i_dm_apb),
    .o_done_imem   (apb_done_imem),
    .o_done_dmem   (apb_done_dmem),
    .o_write       (apb_write),
    .o_rdata       (apb_rdata)
  );

  core_resp_router core_resp_router_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_debug_mode     (i_debug_mode),
    .i_imem_req       (i_imem),
    .i_dmem_req       (i_dmem),
    .i_imem_region    (imem_region),
    .i_dmem_region    (dmem_region),
    .i_ram_imem_valid (ram_imem_valid),
    .i_ram_imem_data  (ram_imem_data),
    .i_ram_dmem_valid (ram_dmem_valid),
    .i_ram_dmem_data  (ram_dmem_data),
    .i_apb_done_imem  (apb_done_imem),
    .i_apb_done_dmem  (apb_done_dmem),
    .i_apb_write      (apb_write),
    .i_apb_rdata      (apb_rdata),
    .o_imem           (o_imem),
    .o_dmem           (o_dmem),
    .o_tohost         (o_tohost)
  );

endmodule

// File: verilog/core_resp_router.sv
/* Combines RAM, APB and immediate answers into the core handshakes
   Unmapped and tohost reads answer zero in debug mode only; tohost writes always ack */
`timescale 1ns/100ps

module core_resp_router
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,
  input  imem_req_t i_imem_req,
  input  dmem_req_t i_dmem_req,
  input  region_t   i_imem_region,
  input  region_t   i_dmem_region,
  input  logic      i_ram_imem_valid,
  input  word_t     i_ram_imem_data,
  input  logic      i_ram_dmem_valid,
  input  word_t     i_ram_dmem_data,
  input  logic      i_apb_done_imem,
  input  logic      i_apb_done_dmem,
  input  logic      i_apb_write,
  input  word_t     i_apb_rdata,
  output core_rsp_t o_imem,
  output core_rsp_t o_dmem,
  output word_t     o_tohost
);

  // Fetch port never writes
  always_comb
  begin
    o_imem = '0;
    case (i_imem_region)
      REG_RAM:
      begin
        o_imem.rvalid = i_ram_imem_valid;
        o_imem.rdata  = i_ram_imem_data;
      end
      REG_DEBUG:
      begin
        o_imem.rvalid = i_apb_done_imem;
        o_imem.rdata  = i_apb_rdata;
      end
      default:
        o_imem.rvalid = i_debug_mode && i_imem_req.rready;
    endcase
  end

  always_comb
  begin
    o_dmem = '0;
    case (i_dmem_region)
      REG_RAM:
      begin
        // Writes complete in the request cycle
        o_dmem.rvalid = i_ram_dmem_valid;
        o_dmem.wready = i_dmem_req.wvalid;
        o_dmem.rdata  = i_ram_dmem_data;
      end
      REG_DEBUG:
      begin
        o_dmem.rvalid = i_apb_done_dmem && !i_apb_write;
        o_dmem.wready = i_apb_done_dmem && i_apb_write;
        o_dmem.rdata  = i_apb_rdata;
      end
      REG_TOHOST:
      begin
        o_dmem.rvalid = i_debug_mode && i_dmem_req.rready;
        o_dmem.wready = i_dmem_req.wvalid;
      end
      default:
      begin
        // Unmapped in debug mode, writes dropped
        o_dmem.rvalid = i_debug_mode && i_dmem_req.rready;
        o_dmem.wready = i_debug_mode && i_dmem_req.wvalid;
      end
    endcase
  end

  // Test status word, last write wins
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (i_dmem_req.wvalid && (i_dmem_region == REG_TOHOST))
      o_tohost <= i_dmem_req.wdata;
  end

endmodule

// File: verilog/debug_apb_master.sv
/* Serves debug-area accesses of both ports, data first, one at a time
   Returns to idle whenever debug mode drops, even mid-transfer */
`timescale 1ns/100ps
`include "mem_subsys_params.svh"

module debug_apb_master
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,
  input  imem_req_t i_imem_req,
  input  dmem_req_t i_dmem_req,
  input  region_t   i_imem_region,
  input  region_t   i_dmem_region,
  output apb_req_t  o_apb,
  input  apb_rsp_t  i_apb,
  output logic      o_done_imem,
  output logic      o_done_dmem,
  output logic      o_write,
  output word_t     o_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_t;

  apb_state_t state;
  apb_state_t state_nxt;
  logic       dmem_hit;
  logic       imem_hit;
  logic       start;
  logic       done;
  logic       owner_dmem;
  logic       pwrite_q;
  apb_addr_t  paddr_q;
  word_t      pwdata_q;

  // Debug region already implies debug mode
  assign dmem_hit = (i_dmem_region == REG_DEBUG) && (i_dmem_req.rready || i_dmem_req.wvalid);
  assign imem_hit = (i_imem_region == REG_DEBUG) && i_imem_req.rready;
  assign start    = (state == ST_IDLE) && (dmem_hit || imem_hit);
  // Error ends the transfer like a normal ready
  assign done     = (state == ST_ACCESS) && (i_apb.pready || i_apb.pslverr);

  // ==================================================
  // FSM
  // ==================================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:   if (start) state_nxt = ST_SETUP;
      ST_SETUP:  state_nxt = ST_ACCESS;
      ST_ACCESS: if (done) state_nxt = ST_IDLE;
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state      <= ST_IDLE;
      owner_dmem <= 1'b0;
      pwrite_q   <= 1'b0;
    end
    else if (!i_debug_mode)
      state <= ST_IDLE;
    else
    begin
      state <= state_nxt;
      if (start)
      begin
        owner_dmem <= dmem_hit;
        pwrite_q   <= dmem_hit && i_dmem_req.wvalid;
      end
    end
  end

  // Transfer address and data, taken from the winning port
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      paddr_q  <= dmem_hit ? i_dmem_req.addr[`MS_APB_ADDR_W-1:0]
                           : i_imem_req.addr[`MS_APB_ADDR_W-1:0];
      pwdata_q <= i_dmem_req.wdata;
    end
  end

  // ==================================================
  // Bus outputs
  // ==================================================
  always_comb
  begin
    o_apb.paddr   = paddr_q;
    o_apb.psel    = (state != ST_IDLE);
    o_apb.penable = (state == ST_ACCESS);
    o_apb.pwrite  = pwrite_q;
    o_apb.pwdata  = pwdata_q;
  end

  assign o_done_imem = done && !owner_dmem;
  assign o_done_dmem = done && owner_dmem;
  assign o_write     = pwrite_q;
  assign o_rdata     = i_apb.prdata;

  // The owning port keeps its request up until the transfer ends
  a_owner_held: assert property (@(posedge clk) disable iff (!reset_n)
    (o_apb.psel && i_debug_mode) |-> (owner_dmem ? dmem_hit : imem_hit));

  // Only debug-area addresses reach the bus
  a_paddr_in_area: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb.psel |-> (o_apb.paddr >= apb_addr_t'(`MS_DBG_START))
                   && (o_apb.paddr <= apb_addr_t'(`MS_DBG_END)));

endmodule

// File: verilog/unified_ram.sv
/* One access per cycle, data write beats data read beats fetch
   Read data arrives two edges after the grant; a held request is issued once */
`timescale 1ns/100ps
`include "mem_subsys_params.svh"

module unified_ram
  import mem_map_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     i_imem_rd,
  input  ram_idx_t i_imem_idx,
  input  logic     i_dmem_rd,
  input  logic     i_dmem_wr,
  input  ram_idx_t i_dmem_idx,
  input  word_t    i_wdata,
  output logic     o_imem_valid,
  output word_t    o_imem_data,
  output logic     o_dmem_valid,
  output word_t    o_dmem_data
);

  word_t    mem [`MS_RAM_WORDS];
  word_t    rd_word;
  ram_idx_t ram_idx;
  logic     gnt_imem;
  logic     gnt_dmem;
  logic     gnt_imem_q;
  logic     gnt_dmem_q;
  logic     imem_busy;
  logic     dmem_busy;

  // ==================================================
  // Port arbiter
  // ==================================================
  always_comb
  begin
    // A pending data read frees the port for a fetch
    gnt_dmem = i_dmem_rd && !dmem_busy;
    gnt_imem = i_imem_rd && !imem_busy && !i_dmem_wr && !gnt_dmem;
    ram_idx  = (i_dmem_wr || gnt_dmem) ? i_dmem_idx : i_imem_idx;
  end

  // Single-port array, write-first on a coinciding read
  always_ff @(posedge clk)
  begin
    if (i_dmem_wr)
      mem[ram_idx] <= i_wdata;
    if (i_dmem_wr && gnt_dmem)
      rd_word <= i_wdata;
    else if (gnt_dmem || gnt_imem)
      rd_word <= mem[ram_idx];
  end

  // ==================================================
  // Grant record and in-progress flags
  // ==================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      gnt_imem_q   <= 1'b0;
      gnt_dmem_q   <= 1'b0;
      o_imem_valid <= 1'b0;
      o_dmem_valid <= 1'b0;
      imem_busy    <= 1'b0;
      dmem_busy    <= 1'b0;
    end
    else
    begin
      gnt_imem_q   <= gnt_imem;
      gnt_dmem_q   <= gnt_dmem;
      o_imem_valid <= gnt_imem_q;
      o_dmem_valid <= gnt_dmem_q;
      // Busy until the valid pulse has been seen by the core
      if (gnt_imem)
        imem_busy <= 1'b1;
      else if (o_imem_valid || !i_imem_rd)
        imem_busy <= 1'b0;
      if (gnt_dmem)
        dmem_busy <= 1'b1;
      else if (o_dmem_valid || !i_dmem_rd)
        dmem_busy <= 1'b0;
    end
  end

  // Steer the read word to the port that won the grant
  always_ff @(posedge clk)
  begin
    if (gnt_imem_q)
      o_imem_data <= rd_word;
    if (gnt_dmem_q)
      o_dmem_data <= rd_word;
  end

  // A valid pulse answers a read that the core still holds
  a_imem_valid_held: assert property (@(posedge clk) disable iff (!reset_n)
    o_imem_valid |-> i_imem_rd);

  a_dmem_valid_held: assert property (@(posedge clk) disable iff (!reset_n)
    o_dmem_valid |-> i_dmem_rd);

endmodule

// File: verilog/region_decoder.sv
/* Debug area decodes only while debug mode is high and wins over all else
   RAM is 16 KB from the base plus the alias at the top of the address space */
`timescale 1ns/100ps
`include "mem_subsys_params.svh"

module region_decoder
  import mem_map_pkg::*;
(
  input  addr_t    i_addr,
  input  logic     i_debug_mode,
  output region_t  o_region,
  output ram_idx_t o_ram_idx
);

  // RAM size in bytes
  localparam addr_t RAM_BYTES = addr_t'(`MS_RAM_WORDS * 4);

  addr_t ram_offset;
  logic  in_debug;
  logic  in_ram_lin;
  logic  in_ram_wrap;

  // Offset from the RAM base, wraps around for lower addresses
  assign ram_offset  = i_addr - addr_t'(`MS_RAM_BASE);
  assign in_debug    = i_debug_mode && (i_addr >= addr_t'(`MS_DBG_START))
                       && (i_addr <= addr_t'(`MS_DBG_END));
  assign in_ram_lin  = (i_addr >= addr_t'(`MS_RAM_BASE)) && (ram_offset < RAM_BYTES);
  assign in_ram_wrap = (i_addr[31:`MS_RAM_IDX_W+2] == `MS_WRAP_TAG);

  // Base is 64 KB aligned, so the offset's low bits index the alias as well
  assign o_ram_idx = ram_offset[`MS_RAM_IDX_W+1:2];

  always_comb
  begin
    if (in_debug)
      o_region = REG_DEBUG;
    else if (in_ram_lin || in_ram_wrap)
      o_region = REG_RAM;
    else if (i_addr == addr_t'(`MS_TOHOST_ADDR))
      o_region = REG_TOHOST;
    else
      o_region = REG_NONE;
  end

endmodule

// File: verilog/mem_bus_pkg.sv
/* Core-side and APB bundles, one request or response per struct
   Field order fixes the packed layout, keep it in step with the testbench */
package mem_bus_pkg;

  import mem_map_pkg::*;

  // Instruction fetch request
  typedef struct packed {
    addr_t addr;
    logic  rready;
  } imem_req_t;

  // Data request, read and write share the address
  typedef struct packed {
    addr_t addr;
    logic  wvalid;
    word_t wdata;
    logic  rready;
  } dmem_req_t;

  // Response back to either core port
  typedef struct packed {
    logic  rvalid;
    logic  wready;
    word_t rdata;
  } core_rsp_t;

  // APB master outputs
  typedef struct packed {
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
  } apb_req_t;

  // APB slave outputs
  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

endpackage

// File: verilog/mem_map_pkg.sv
/* Address, data and region types of the memory map */
`include "mem_subsys_params.svh"

package mem_map_pkg;

  // Byte address as issued by the core
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [31:0] word_t;

  // Word index into the unified RAM
  typedef logic [`MS_RAM_IDX_W-1:0] ram_idx_t;

  // Address on the debug module APB
  typedef logic [`MS_APB_ADDR_W-1:0] apb_addr_t;

  // Target of one core access
  typedef enum logic [1:0] {
    REG_RAM,
    REG_DEBUG,
    REG_TOHOST,
    REG_NONE
  } region_t;

endpackage

// File: verilog/mem_subsys_params.svh
/* Address map and widths of the memory subsystem
   RAM depth and index width must agree, 4096 words need 12 index bits */
`ifndef MEM_SUBSYS_PARAMS_SVH
`define MEM_SUBSYS_PARAMS_SVH

// ==================================================
// Program RAM
// ==================================================
`define MS_RAM_BASE     32'h0001_0000
`define MS_RAM_WORDS    4096
`define MS_RAM_IDX_W    12
// Upper 18 address bits of the RAM alias at the top of memory
`define MS_WRAP_TAG     18'h3_FFFF

// ==================================================
// Debug area, tohost and APB
// ==================================================
`define MS_DBG_START    32'h0000_0200
`define MS_DBG_END      32'h0000_0FFF
`define MS_TOHOST_ADDR  32'h8000_1000
`define MS_APB_ADDR_W   13

`endif
